// File: compile.f
verilog/soc_pkg.sv
verilog/mem_ram.sv
verilog/sys_ctrl.sv
verilog/uart.sv
verilog/bus_fabric.sv
verilog/mini_soc.sv
testbench/mini_soc_tb.sv

// File: Bender.yml
package:
  name: mini_soc

sources:
  - verilog/soc_pkg.sv
  - verilog/mem_ram.sv
  - verilog/sys_ctrl.sv
  - verilog/uart.sv
  - verilog/bus_fabric.sv
  - verilog/mini_soc.sv
  - target: test
    files:
      - testbench/mini_soc_tb.sv

// File: testbench/mini_soc_tb.sv
module mini_soc_tb;

    localparam int NO_MEMS   = 3;
    localparam int MEM_WORDS = 256;
    localparam int UART_DIV  = 8;

    typedef enum {WRITE, READ, PAUSE_SET, PAUSE_CLR, UART_WAIT} kind_t;

    typedef struct {
        string          name;
        kind_t          kind;
        soc_pkg::addr_t addr;
        soc_pkg::word_t data;
        soc_pkg::word_t exp;
        logic           err;
    } entry_t;

    logic           clk;
    logic           rst_n;
    logic           bus_req;
    logic           bus_we;
    soc_pkg::addr_t bus_addr;
    soc_pkg::word_t bus_wdata;
    logic           bus_rvalid;
    logic           bus_err;
    soc_pkg::word_t bus_rdata;
    logic           pause_req;
    logic           pause_ack;
    logic           uart_tx;
    logic           uart_rx;

    entry_t         tbl [$];
    logic [31:0]    lfsr = 32'h5ecc;
    int             uart_entries = 0;
    int             word_errs = 0;
    int             bit_errs = 0;
    int             cycles = 0;
    int             limit = 0;

    mini_soc #(
        .NO_MEMS   (NO_MEMS),
        .MEM_WORDS (MEM_WORDS)
    ) i_mini_soc (.*);

    always #4 clk = ~clk;

    // serial loopback from the transmitter into the receiver.
    always @(uart_tx) begin
        uart_rx = uart_tx;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ******************************
    // helpers
    // ******************************

    // fibonacci lfsr with taps 32, 22, 2 and 1, one step per bit.
    function automatic soc_pkg::word_t take_bits(int n);
        soc_pkg::word_t v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic soc_pkg::addr_t mem_addr(int mem, int word);
        return soc_pkg::MEM_BASE + soc_pkg::MEM_SPAN * mem + 4 * word;
    endfunction

    task automatic add_entry(input string name, input kind_t kind, input soc_pkg::addr_t addr,
                             input soc_pkg::word_t data, input soc_pkg::word_t exp,
                             input logic err);
        tbl.push_back('{name, kind, addr, data, exp, err});
        if (kind == UART_WAIT) begin
            uart_entries++;
        end
    endtask

    task automatic check_word(input string name, input soc_pkg::word_t exp,
                              input soc_pkg::word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            word_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            bit_errs++;
        end
    endtask

    // called on a falling edge and returns on the falling edge of the rvalid cycle.
    task automatic issue_access(input logic we, input soc_pkg::addr_t addr,
                                input soc_pkg::word_t data);
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = data;
        @(negedge clk);
        bus_req   = 1'b0;
        bus_we    = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        case (e.kind)
            WRITE, READ: begin
                issue_access(e.kind == WRITE, e.addr, e.data);
                check_bit({e.name, " rvalid"}, 1'b1, bus_rvalid);
                check_bit({e.name, " err"}, e.err, bus_err);
                check_word(e.name, e.exp, bus_rdata);
            end
            PAUSE_SET, PAUSE_CLR: begin
                pause_req = (e.kind == PAUSE_SET);
                repeat (2) @(negedge clk);
                check_bit(e.name, e.exp[0], pause_ack);
            end
            default: begin
                do begin
                    issue_access(1'b0, e.addr, '0);
                end while (!bus_rdata[9]);
                check_word(e.name, e.exp, bus_rdata);
            end
        endcase
    endtask

    // ******************************
    // stimulus table
    // ******************************

    task automatic build_table();
        soc_pkg::word_t     wdat [NO_MEMS][2];
        soc_pkg::addr_t     pause_reg;
        soc_pkg::addr_t     status_reg;
        soc_pkg::addr_t     uart_status;
        soc_pkg::uart_reg_t cfg;
        soc_pkg::uart_reg_t txw;

        pause_reg   = soc_pkg::SYS_BASE + soc_pkg::SYS_PAUSE_OFS;
        status_reg  = soc_pkg::SYS_BASE + soc_pkg::SYS_STATUS_OFS;
        uart_status = soc_pkg::UART_BASE + soc_pkg::UART_STATUS_OFS;

        // first and last word of every memory.
        for (int i = 0; i < NO_MEMS; i++) begin
            for (int k = 0; k < 2; k++) begin
                wdat[i][k] = take_bits(32);
                add_entry($sformatf("mem%0d write %0d", i, k), WRITE,
                          mem_addr(i, k * (MEM_WORDS - 1)), wdat[i][k], '0, 1'b0);
            end
        end
        for (int i = 0; i < NO_MEMS; i++) begin
            for (int k = 0; k < 2; k++) begin
                add_entry($sformatf("mem%0d read %0d", i, k), READ,
                          mem_addr(i, k * (MEM_WORDS - 1)), '0, wdat[i][k], 1'b0);
            end
        end
        add_entry("offset past size", READ, mem_addr(0, MEM_WORDS), '0, '0, 1'b1);
        add_entry("unmapped address", READ, 32'h3000_0000, '0, '0, 1'b1);

        // memory 1 is cleared alone. memory 0 goes first since the clear lands a cycle late.
        add_entry("srst mem1", WRITE, soc_pkg::SYS_BASE + soc_pkg::SYS_SRST_OFS, 32'h2, '0, 1'b0);
        for (int i = 0; i < NO_MEMS; i++) begin
            add_entry($sformatf("mem%0d after srst", i), READ, mem_addr(i, 0), '0,
                      (i == 1) ? 32'h0 : wdat[i][0], 1'b0);
        end

        add_entry("pause mask set", WRITE, pause_reg, 32'h4, '0, 1'b0);
        add_entry("pause mask read", READ, pause_reg, '0, 32'h4, 1'b0);
        add_entry("status mask", READ, status_reg, '0, 32'h4, 1'b0);
        add_entry("paused read", READ, mem_addr(2, 0), '0, '0, 1'b1);
        add_entry("paused write", WRITE, mem_addr(2, MEM_WORDS - 1), ~wdat[2][1], '0, 1'b1);
        add_entry("pause mask clear", WRITE, pause_reg, 32'h0, '0, 1'b0);
        add_entry("pause mask cleared", READ, pause_reg, '0, '0, 1'b0);
        for (int k = 0; k < 2; k++) begin
            add_entry($sformatf("mem2 resumed %0d", k), READ,
                      mem_addr(2, k * (MEM_WORDS - 1)), '0, wdat[2][k], 1'b0);
        end

        add_entry("system pause on", PAUSE_SET, '0, '0, 32'h1, 1'b0);
        add_entry("status all paused", READ, status_reg, '0,
                  32'h8000_0000 | ((1 << NO_MEMS) - 1), 1'b0);
        for (int i = 0; i < NO_MEMS; i++) begin
            add_entry($sformatf("mem%0d system paused", i), READ, mem_addr(i, 0), '0, '0, 1'b1);
        end
        add_entry("system pause off", PAUSE_CLR, '0, '0, 32'h0, 1'b0);
        add_entry("mem0 after pause", READ, mem_addr(0, 0), '0, wdat[0][0], 1'b0);

        cfg             = '0;
        cfg.cfg.enable  = 1'b1;
        cfg.cfg.divisor = 16'(UART_DIV);
        txw             = '0;
        txw.tx.data     = 8'(take_bits(8));
        add_entry("uart cfg", WRITE, soc_pkg::UART_BASE + soc_pkg::UART_CFG_OFS, cfg, '0, 1'b0);
        add_entry("uart cfg read", READ, soc_pkg::UART_BASE + soc_pkg::UART_CFG_OFS, '0, cfg,
                  1'b0);
        add_entry("uart tx", WRITE, soc_pkg::UART_BASE + soc_pkg::UART_TX_OFS, txw, '0, 1'b0);
        add_entry("uart rx byte", UART_WAIT, uart_status, '0, 32'h200 | txw, 1'b0);
        add_entry("uart rx cleared", READ, uart_status, '0, txw, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        pause_req = 1'b0;
        uart_rx   = 1'b1;
        build_table();
        limit = tbl.size() * 20 + uart_entries * 12 * UART_DIV;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_bit("uart tx idle after reset", 1'b1, uart_tx);
        foreach (tbl[n]) begin
            apply_entry(tbl[n]);
        end
        $display("errors: %0d word mismatches, %0d flag mismatches", word_errs, bit_errs);
        if (word_errs + bit_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/mini_soc.sv
module mini_soc #(
    parameter int NO_MEMS   = 3,
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst_n,

    input  logic           bus_req,
    input  logic           bus_we,
    input  soc_pkg::addr_t bus_addr,
    input  soc_pkg::word_t bus_wdata,
    output logic           bus_rvalid,
    output logic           bus_err,
    output soc_pkg::word_t bus_rdata,

    input  logic           pause_req,
    output logic           pause_ack,

    output logic           uart_tx,
    input  logic           uart_rx
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [NO_MEMS-1:0] mem_req;
    logic [NO_MEMS-1:0] mem_srst;
    logic [NO_MEMS-1:0] mem_pause_req;
    logic [NO_MEMS-1:0] mem_pause_ack;
    soc_pkg::word_t     mem_rdata [NO_MEMS];

    logic               sys_req;
    logic               uart_req;
    soc_pkg::word_t     sys_rdata;
    soc_pkg::word_t     uart_rdata;

    bus_fabric #(
        .NO_MEMS   (NO_MEMS),
        .MEM_WORDS (MEM_WORDS)
    ) i_bus_fabric (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus_req       (bus_req),
        .bus_we        (bus_we),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_rvalid    (bus_rvalid),
        .bus_rdata     (bus_rdata),
        .bus_err       (bus_err),
        .mem_req       (mem_req),
        .mem_rdata     (mem_rdata),
        .mem_pause_ack (mem_pause_ack),
        .sys_req       (sys_req),
        .uart_req      (uart_req),
        .sys_rdata     (sys_rdata),
        .uart_rdata    (uart_rdata)
    );

    sys_ctrl #(
        .NO_MEMS (NO_MEMS)
    ) i_sys_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (sys_req),
        .we            (bus_we),
        .offset        (bus_addr[3:0]),
        .wdata         (bus_wdata),
        .rdata         (sys_rdata),
        .pause_req     (pause_req),
        .pause_ack     (pause_ack),
        .mem_srst      (mem_srst),
        .mem_pause_req (mem_pause_req),
        .mem_pause_ack (mem_pause_ack)
    );

    uart i_uart (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (uart_req),
        .we     (bus_we),
        .offset (bus_addr[3:0]),
        .wdata  (bus_wdata),
        .rdata  (uart_rdata),
        .tx     (uart_tx),
        .rx     (uart_rx)
    );

    // word index sits above the byte offset bits of the address.
    for (genvar i = 0; i < NO_MEMS; i++) begin : g_mem
        mem_ram #(
            .MEM_WORDS (MEM_WORDS)
        ) i_mem_ram (
            .clk       (clk),
            .rst_n     (rst_n),
            .srst      (mem_srst[i]),
            .req       (mem_req[i]),
            .we        (bus_we),
            .index     (bus_addr[IDX_W+1:2]),
            .wdata     (bus_wdata),
            .rdata     (mem_rdata[i]),
            .pause_req (mem_pause_req[i]),
            .pause_ack (mem_pause_ack[i])
        );
    end

endmodule

// File: verilog/bus_fabric.sv
module bus_fabric #(
    parameter int NO_MEMS   = 3,
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               bus_req,
    input  logic               bus_we,
    input  soc_pkg::addr_t     bus_addr,
    input  soc_pkg::word_t     bus_wdata,
    output logic               bus_rvalid,
    output soc_pkg::word_t     bus_rdata,
    output logic               bus_err,

    output logic [NO_MEMS-1:0] mem_req,
    input  soc_pkg::word_t     mem_rdata [NO_MEMS],
    input  logic [NO_MEMS-1:0] mem_pause_ack,

    output logic               sys_req,
    output logic               uart_req,
    input  soc_pkg::word_t     sys_rdata,
    input  soc_pkg::word_t     uart_rdata
);

    soc_pkg::addr_t     mem_off;
    soc_pkg::addr_t     mem_id;
    soc_pkg::addr_t     word_idx;
    logic               hit;
    logic [NO_MEMS-1:0] mem_sel_q;
    logic               sys_sel_q;
    logic               uart_sel_q;
    logic               err_q;
    logic               rvalid_q;

    // ******************************
    // request decode
    // ******************************

    assign mem_off  = bus_addr - soc_pkg::MEM_BASE;
    assign mem_id   = mem_off / soc_pkg::MEM_SPAN;
    assign word_idx = (mem_off % soc_pkg::MEM_SPAN) >> 2;

    // a paused memory or an offset past its size gets no strobe.
    always_comb begin
        mem_req = '0;
        for (int i = 0; i < NO_MEMS; i++) begin
            mem_req[i] = bus_req && (mem_id == soc_pkg::addr_t'(i))
                && (word_idx < MEM_WORDS) && !mem_pause_ack[i];
        end
    end

    assign sys_req  = bus_req && ((bus_addr - soc_pkg::SYS_BASE) < soc_pkg::REG_SPAN);
    assign uart_req = bus_req && ((bus_addr - soc_pkg::UART_BASE) < soc_pkg::REG_SPAN);
    assign hit      = (|mem_req) || sys_req || uart_req;

    // ******************************
    // response
    // ******************************

    // selects are kept for reads only so that writes return zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q   <= 1'b0;
            err_q      <= 1'b0;
            mem_sel_q  <= '0;
            sys_sel_q  <= 1'b0;
            uart_sel_q <= 1'b0;
        end else begin
            rvalid_q   <= bus_req;
            err_q      <= bus_req && !hit;
            mem_sel_q  <= mem_req & {NO_MEMS{!bus_we}};
            sys_sel_q  <= sys_req && !bus_we;
            uart_sel_q <= uart_req && !bus_we;
        end
    end

    always_comb begin
        bus_rdata = '0;
        for (int i = 0; i < NO_MEMS; i++) begin
            if (mem_sel_q[i]) begin
                bus_rdata = mem_rdata[i];
            end
        end
        if (sys_sel_q) begin
            bus_rdata = sys_rdata;
        end
        if (uart_sel_q) begin
            bus_rdata = uart_rdata;
        end
    end

    assign bus_rvalid = rvalid_q;
    assign bus_err    = err_q;

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({mem_req, sys_req, uart_req}));

    // write data goes to the targets directly and must be defined.
    assert property (@(posedge clk) disable iff (!rst_n)
        bus_req && bus_we |-> !$isunknown(bus_wdata));

endmodule

// File: verilog/uart.sv
module uart (
    input  logic           clk,
    input  logic           rst_n,

    input  logic           req,
    input  logic           we,
    input  logic [3:0]     offset,
    input  soc_pkg::word_t wdata,
    output soc_pkg::word_t rdata,

    output logic           tx,
    input  logic           rx
);

    soc_pkg::uart_reg_t wreg;
    soc_pkg::uart_reg_t cfg_view;
    logic               cfg_en;
    logic [15:0]        cfg_div;
    logic               uart_on;
    logic               tx_start;
    logic               status_rd;

    logic               tx_busy;
    logic [8:0]         tx_shift;
    logic [3:0]         tx_bits;
    logic [15:0]        tx_cnt;

    logic [1:0]         rx_sync;
    logic               rx_busy;
    logic [3:0]         rx_bits;
    logic [15:0]        rx_cnt;
    logic               rx_mid;
    logic               rx_done;
    logic [7:0]         rx_shift;
    logic [7:0]         rx_data;
    logic               rx_valid;

    assign wreg      = wdata;
    assign uart_on   = cfg_en && (cfg_div != '0);
    assign tx_start  = req && we && (offset == soc_pkg::UART_TX_OFS) && uart_on && !tx_busy;
    assign status_rd = req && !we && (offset == soc_pkg::UART_STATUS_OFS);

    always_comb begin
        cfg_view             = '0;
        cfg_view.cfg.enable  = cfg_en;
        cfg_view.cfg.divisor = cfg_div;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_en  <= 1'b0;
            cfg_div <= '0;
        end else if (req && we && (offset == soc_pkg::UART_CFG_OFS)) begin
            cfg_en  <= wreg.cfg.enable;
            cfg_div <= wreg.cfg.divisor;
        end
    end

    // ******************************
    // transmitter
    // ******************************

    // the start bit goes out at once, the stop bit is the last shifted one.
    always_ff @(posedge clk) begin
        if (!rst_n || !uart_on) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            tx_bits <= '0;
            tx_cnt  <= '0;
        end else if (tx_start) begin
            tx       <= 1'b0;
            tx_busy  <= 1'b1;
            tx_shift <= {1'b1, wreg.tx.data};
            tx_bits  <= 4'd9;
            tx_cnt   <= '0;
        end else if (tx_busy) begin
            if (tx_cnt == cfg_div - 16'd1) begin
                tx_cnt <= '0;
                if (tx_bits == '0) begin
                    tx_busy <= 1'b0;
                end else begin
                    tx       <= tx_shift[0];
                    tx_shift <= {1'b1, tx_shift[8:1]};
                    tx_bits  <= tx_bits - 4'd1;
                end
            end else begin
                tx_cnt <= tx_cnt + 16'd1;
            end
        end
    end

    // ******************************
    // receiver
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_mid  = rx_busy && (rx_cnt == (cfg_div >> 1));
    assign rx_done = rx_mid && (rx_bits == 4'd9) && rx_sync[1];

    // bit 0 is the start bit, 1 to 8 carry data and 9 is the stop bit.
    always_ff @(posedge clk) begin
        if (!rst_n || !uart_on) begin
            rx_busy <= 1'b0;
            rx_bits <= '0;
            rx_cnt  <= '0;
        end else if (!rx_busy) begin
            rx_busy <= !rx_sync[1];
            rx_bits <= '0;
            rx_cnt  <= '0;
        end else begin
            if (rx_cnt == cfg_div - 16'd1) begin
                rx_cnt  <= '0;
                rx_bits <= rx_bits + 4'd1;
            end else begin
                rx_cnt <= rx_cnt + 16'd1;
            end
            if (rx_mid) begin
                if ((rx_bits == '0 && rx_sync[1]) || rx_bits == 4'd9) begin
                    rx_busy <= 1'b0;
                end else if (rx_bits != '0) begin
                    rx_shift <= {rx_sync[1], rx_shift[7:1]};
                end
            end
        end
    end

    // a byte arriving in the same cycle as a status read stays valid.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
            rx_data  <= '0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
            rx_data  <= rx_shift;
        end else if (status_rd) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (offset)
                soc_pkg::UART_CFG_OFS:    rdata <= cfg_view;
                soc_pkg::UART_STATUS_OFS: rdata <= {22'd0, rx_valid, tx_busy, rx_data};
                default:                  rdata <= '0;
            endcase
        end
    end

    // outside a frame the line rests high, and a disabled UART is never busy.
    assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx);

endmodule

// File: verilog/sys_ctrl.sv
module sys_ctrl #(
    parameter int NO_MEMS = 3
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               req,
    input  logic               we,
    input  logic [3:0]         offset,
    input  soc_pkg::word_t     wdata,
    output soc_pkg::word_t     rdata,

    input  logic               pause_req,
    output logic               pause_ack,

    output logic [NO_MEMS-1:0] mem_srst,
    output logic [NO_MEMS-1:0] mem_pause_req,
    input  logic [NO_MEMS-1:0] mem_pause_ack
);

    logic [NO_MEMS-1:0] pause_mask;
    logic               wr_srst;
    logic               wr_pause;
    soc_pkg::word_t     status;

    assign wr_srst  = req && we && (offset == soc_pkg::SYS_SRST_OFS);
    assign wr_pause = req && we && (offset == soc_pkg::SYS_PAUSE_OFS);

    // the system request pauses every memory on top of its own mask bit.
    assign mem_pause_req = pause_mask | {NO_MEMS{pause_req}};
    assign pause_ack     = &mem_pause_ack;

    always_comb begin
        status                = '0;
        status[NO_MEMS-1:0]   = mem_pause_ack;
        status[31]            = pause_ack;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause_mask <= '0;
        end else if (wr_pause) begin
            pause_mask <= wdata[NO_MEMS-1:0];
        end
    end

    // a set mask bit gives a single cycle clear to that memory.
    // bits already pulsing are not extended by a back-to-back write.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_srst <= '0;
        end else if (wr_srst) begin
            mem_srst <= wdata[NO_MEMS-1:0] & ~mem_srst;
        end else begin
            mem_srst <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (offset)
                soc_pkg::SYS_PAUSE_OFS:  rdata <= soc_pkg::word_t'(pause_mask);
                soc_pkg::SYS_STATUS_OFS: rdata <= status;
                default:                 rdata <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_srst & $past(mem_srst)) == '0);

endmodule

// File: verilog/mem_ram.sv
module mem_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         srst,

    input  logic                         req,
    input  logic                         we,
    input  logic [$clog2(MEM_WORDS)-1:0] index,
    input  soc_pkg::word_t               wdata,
    output soc_pkg::word_t               rdata,

    input  logic                         pause_req,
    output logic                         pause_ack
);

    soc_pkg::word_t       mem [MEM_WORDS];
    logic [MEM_WORDS-1:0] valid;

    // a word that has not been written since the last clear reads as zero.
    always_ff @(posedge clk) begin
        if (!rst_n || srst) begin
            valid <= '0;
        end else if (req && we) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req && we) begin
            mem[index] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (valid[index]) begin
                rdata <= mem[index];
            end else begin
                rdata <= '0;
            end
        end
    end

    // acknowledge follows the request one cycle later in both directions.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req;
        end
    end

    // the fabric must stop issuing strobes once the pause is acknowledged.
    assert property (@(posedge clk) disable iff (!rst_n) pause_ack |-> !req);

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    // ******************************
    // address map
    // ******************************

    localparam addr_t MEM_BASE  = 32'h0000_0000;
    localparam addr_t SYS_BASE  = 32'h1000_0000;
    localparam addr_t UART_BASE = 32'h2000_0000;
    localparam addr_t MEM_SPAN  = 32'h0100_0000;

    // register blocks decode a 16 byte window above their base.
    localparam addr_t REG_SPAN = 32'h0000_0010;

    localparam logic [3:0] SYS_SRST_OFS   = 4'h0;
    localparam logic [3:0] SYS_PAUSE_OFS  = 4'h4;
    localparam logic [3:0] SYS_STATUS_OFS = 4'h8;

    localparam logic [3:0] UART_TX_OFS     = 4'h0;
    localparam logic [3:0] UART_CFG_OFS    = 4'h4;
    localparam logic [3:0] UART_STATUS_OFS = 4'h8;

    // the same bus word means a tx byte or a configuration, by offset.
    typedef union packed {
        struct packed {
            logic [23:0] rsvd;
            logic [7:0]  data;
        } tx;
        struct packed {
            logic [14:0] rsvd;
            logic        enable;
            logic [15:0] divisor;
        } cfg;
    } uart_reg_t;

endpackage
